//--- flist.f
rtl/isa_pkg.sv
rtl/core_pkg.sv
rtl/core_ifs.sv
rtl/rename_dispatch.sv
rtl/phys_regfile.sv
rtl/issue_queue.sv
rtl/reorder_buffer.sv
rtl/ooo_core.sv
verif/tb_ooo_core.sv

//--- rtl/core_ifs.sv
`timescale 1ns/1ps

// Renamed instruction handed to the ROB and the issue queue
interface dispatch_if;
    import core_pkg::*;

    logic     valid;
    areg_t    arch_rd;
    preg_t    phys_rd;
    preg_t    old_phys_rd;                    // Mapping released at commit
    preg_t    phys_rs1;
    preg_t    phys_rs2;
    logic     rs1_ready;
    logic     rs2_ready;
    xdata_t   rs1_value;
    xdata_t   rs2_value;
    xdata_t   imm;
    logic     use_imm;
    logic     is_sub;
    rob_idx_t rob_idx;                        // ROB tail
    logic     rob_full;
    logic     iq_full;

    modport rename (
        output valid, arch_rd, phys_rd, old_phys_rd, phys_rs1, phys_rs2,
               rs1_ready, rs2_ready, rs1_value, rs2_value, imm, use_imm, is_sub,
        input  rob_full, iq_full
    );
    modport rob (
        input  valid, arch_rd, old_phys_rd,
        output rob_idx, rob_full
    );
    modport iq (
        input  valid, phys_rd, phys_rs1, phys_rs2, rs1_ready, rs2_ready,
               rs1_value, rs2_value, imm, use_imm, is_sub, rob_idx,
        output iq_full
    );
endinterface

// Writeback broadcast, one pulse per completed instruction
interface result_if;
    import core_pkg::*;

    logic     valid;
    rob_idx_t rob_idx;
    preg_t    phys_rd;
    xdata_t   result;

    modport src (output valid, rob_idx, phys_rd, result);
    modport dst (input valid, rob_idx, phys_rd, result);
endinterface

//--- rtl/core_pkg.sv
package core_pkg;

    localparam int XLEN      = 32;
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 48;
    localparam int ROB_DEPTH = 8;
    localparam int IQ_DEPTH  = 4;

    // Registers that are not mapped after reset
    localparam int FREE_REGS = PHYS_REGS - ARCH_REGS;

    localparam int AREG_W = $clog2(ARCH_REGS);
    localparam int PREG_W = $clog2(PHYS_REGS);
    localparam int ROB_W  = $clog2(ROB_DEPTH);
    localparam int FREE_W = $clog2(FREE_REGS);

    typedef logic [AREG_W-1:0] areg_t;
    typedef logic [PREG_W-1:0] preg_t;
    typedef logic [ROB_W-1:0]  rob_idx_t;
    typedef logic [XLEN-1:0]   xdata_t;

endpackage

//--- rtl/isa_pkg.sv
package isa_pkg;

    // Integer subset handled by the core
    localparam logic [6:0] OPCODE_ARITH_I = 7'b0010011;
    localparam logic [6:0] OPCODE_ARITH_R = 7'b0110011;

    // Bit 5 of funct7 turns ADD into SUB
    localparam int FUNCT7_SUB_BIT = 5;

    // One instruction word, two field layouts
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;                                  // Register-register form
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;                                  // Register-immediate form
    } instr_u;

endpackage

//--- rtl/issue_queue.sv
`timescale 1ns/1ps

module issue_queue (
    input  logic    clk,
    input  logic    rst,
    dispatch_if.iq  disp,
    result_if.src   wb
);
    import core_pkg::*;

    // Entry 0 is the oldest, the queue collapses on issue
    logic [IQ_DEPTH-1:0] valid_q;
    logic [IQ_DEPTH-1:0] rdy1_q;
    logic [IQ_DEPTH-1:0] rdy2_q;
    logic [IQ_DEPTH-1:0] sub_q;
    rob_idx_t            rob_q [IQ_DEPTH];
    preg_t               prd_q [IQ_DEPTH];
    preg_t               tag1_q [IQ_DEPTH];
    preg_t               tag2_q [IQ_DEPTH];
    xdata_t              val1_q [IQ_DEPTH];
    xdata_t              val2_q [IQ_DEPTH];  // rs2 value or immediate

    logic [IQ_DEPTH-1:0] valid_d;
    logic [IQ_DEPTH-1:0] rdy1_d;
    logic [IQ_DEPTH-1:0] rdy2_d;
    logic [IQ_DEPTH-1:0] sub_d;
    rob_idx_t            rob_d [IQ_DEPTH];
    preg_t               prd_d [IQ_DEPTH];
    preg_t               tag1_d [IQ_DEPTH];
    preg_t               tag2_d [IQ_DEPTH];
    xdata_t              val1_d [IQ_DEPTH];
    xdata_t              val2_d [IQ_DEPTH];

    logic [IQ_DEPTH-1:0] hit1;
    logic [IQ_DEPTH-1:0] hit2;
    logic                issue_fire;
    int                  issue_idx;
    xdata_t              alu_out;

    // Result register feeding the broadcast
    logic     res_valid_q;
    rob_idx_t res_rob_q;
    preg_t    res_prd_q;
    xdata_t   res_val_q;

    assign disp.iq_full = &valid_q;

    always_comb begin
        int src;
        int fill;
        int ins_idx;
        issue_fire = 1'b0;
        issue_idx  = 0;
        fill       = 0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            hit1[i] = res_valid_q && !rdy1_q[i] && tag1_q[i] == res_prd_q;
            hit2[i] = res_valid_q && !rdy2_q[i] && tag2_q[i] == res_prd_q;
            fill    = fill + int'(valid_q[i]);
            if (valid_q[i] && rdy1_q[i] && rdy2_q[i]) begin
                issue_fire = 1'b1;            // Lowest index wins
                issue_idx  = i;
            end
        end
        // Shift younger entries down over the issued one
        for (int i = 0; i < IQ_DEPTH; i++) begin
            src = (issue_fire && i >= issue_idx && i < IQ_DEPTH - 1) ? i + 1 : i;
            valid_d[i] = (issue_fire && i >= issue_idx && src == i) ? 1'b0 : valid_q[src];
            rob_d[i]   = rob_q[src];
            prd_d[i]   = prd_q[src];
            tag1_d[i]  = tag1_q[src];
            tag2_d[i]  = tag2_q[src];
            sub_d[i]   = sub_q[src];
            rdy1_d[i]  = rdy1_q[src] | hit1[src];
            rdy2_d[i]  = rdy2_q[src] | hit2[src];
            val1_d[i]  = hit1[src] ? res_val_q : val1_q[src];
            val2_d[i]  = hit2[src] ? res_val_q : val2_q[src];
        end
        ins_idx = fill - int'(issue_fire);
        if (disp.valid) begin
            valid_d[ins_idx] = 1'b1;
            rob_d[ins_idx]   = disp.rob_idx;
            prd_d[ins_idx]   = disp.phys_rd;
            tag1_d[ins_idx]  = disp.phys_rs1;
            tag2_d[ins_idx]  = disp.phys_rs2;
            sub_d[ins_idx]   = disp.is_sub;
            rdy1_d[ins_idx]  = disp.rs1_ready;
            rdy2_d[ins_idx]  = disp.use_imm | disp.rs2_ready;
            val1_d[ins_idx]  = disp.rs1_value;
            val2_d[ins_idx]  = disp.use_imm ? disp.imm : disp.rs2_value;
        end
    end

    // Add/subtract unit
    assign alu_out = sub_q[issue_idx] ? val1_q[issue_idx] - val2_q[issue_idx]
                                      : val1_q[issue_idx] + val2_q[issue_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q     <= '0;
            res_valid_q <= 1'b0;
        end else begin
            valid_q     <= valid_d;
            res_valid_q <= issue_fire;
        end
    end

    always_ff @(posedge clk) begin
        rdy1_q <= rdy1_d;
        rdy2_q <= rdy2_d;
        sub_q  <= sub_d;
        rob_q  <= rob_d;
        prd_q  <= prd_d;
        tag1_q <= tag1_d;
        tag2_q <= tag2_d;
        val1_q <= val1_d;
        val2_q <= val2_d;
        if (issue_fire) begin
            res_rob_q <= rob_q[issue_idx];
            res_prd_q <= prd_q[issue_idx];
            res_val_q <= alu_out;
        end
    end

    assign wb.valid   = res_valid_q;
    assign wb.rob_idx = res_rob_q;
    assign wb.phys_rd = res_prd_q;
    assign wb.result  = res_val_q;

endmodule

//--- rtl/ooo_core.sv
`timescale 1ns/1ps

module ooo_core (
    input  logic              clk,
    input  logic              rst,
    input  logic              instr_valid_i,
    input  isa_pkg::instr_u   instr_i,
    output logic              stall_o,
    output logic              commit_valid_o,
    output core_pkg::areg_t   commit_rd_o,
    output core_pkg::xdata_t  commit_data_o
);
    import core_pkg::*;

    dispatch_if disp_bus ();
    result_if   wb_bus ();

    preg_t  prf_tag1;
    preg_t  prf_tag2;
    xdata_t prf_val1;
    xdata_t prf_val2;
    logic   prf_rdy1;
    logic   prf_rdy2;
    logic   free_valid;
    preg_t  free_preg;                        // Released at commit

    rename_dispatch u_rename (
        .clk           (clk),
        .rst           (rst),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .stall_o       (stall_o),
        .disp          (disp_bus.rename),
        .rd_tag1_o     (prf_tag1),
        .rd_tag2_o     (prf_tag2),
        .rd_val1_i     (prf_val1),
        .rd_val2_i     (prf_val2),
        .rd_rdy1_i     (prf_rdy1),
        .rd_rdy2_i     (prf_rdy2),
        .free_valid_i  (free_valid),
        .free_preg_i   (free_preg)
    );

    // Dispatch clears the ready bit of the new destination
    phys_regfile u_prf (
        .clk           (clk),
        .rst           (rst),
        .wb            (wb_bus.dst),
        .rd_tag1_i     (prf_tag1),
        .rd_tag2_i     (prf_tag2),
        .rd_val1_o     (prf_val1),
        .rd_val2_o     (prf_val2),
        .rd_rdy1_o     (prf_rdy1),
        .rd_rdy2_o     (prf_rdy2),
        .alloc_valid_i (disp_bus.valid),
        .alloc_preg_i  (disp_bus.phys_rd)
    );

    issue_queue u_iq (
        .clk  (clk),
        .rst  (rst),
        .disp (disp_bus.iq),
        .wb   (wb_bus.src)
    );

    reorder_buffer u_rob (
        .clk            (clk),
        .rst            (rst),
        .disp           (disp_bus.rob),
        .wb             (wb_bus.dst),
        .free_valid_o   (free_valid),
        .free_preg_o    (free_preg),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o)
    );

endmodule

//--- rtl/phys_regfile.sv
`timescale 1ns/1ps

module phys_regfile (
    input  logic              clk,
    input  logic              rst,
    result_if.dst             wb,
    input  core_pkg::preg_t   rd_tag1_i,
    input  core_pkg::preg_t   rd_tag2_i,
    output core_pkg::xdata_t  rd_val1_o,
    output core_pkg::xdata_t  rd_val2_o,
    output logic              rd_rdy1_o,
    output logic              rd_rdy2_o,
    input  logic              alloc_valid_i,
    input  core_pkg::preg_t   alloc_preg_i
);
    import core_pkg::*;

    xdata_t               regs_q [PHYS_REGS];
    logic [PHYS_REGS-1:0] ready_q;
    logic                 fwd1;
    logic                 fwd2;

    // Bypass a write landing this cycle, tag 0 never forwards
    assign fwd1 = wb.valid && (wb.phys_rd == rd_tag1_i) && (rd_tag1_i != '0);
    assign fwd2 = wb.valid && (wb.phys_rd == rd_tag2_i) && (rd_tag2_i != '0);

    assign rd_val1_o = fwd1 ? wb.result : regs_q[rd_tag1_i];
    assign rd_val2_o = fwd2 ? wb.result : regs_q[rd_tag2_i];
    assign rd_rdy1_o = fwd1 | ready_q[rd_tag1_i];
    assign rd_rdy2_o = fwd2 | ready_q[rd_tag2_i];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PHYS_REGS; i++) begin
                regs_q[i]  <= '0;
                ready_q[i] <= i < ARCH_REGS;  // Architectural state starts valid
            end
        end else begin
            if (alloc_valid_i && alloc_preg_i != '0) begin
                ready_q[alloc_preg_i] <= 1'b0;
            end
            if (wb.valid && wb.phys_rd != '0) begin
                regs_q[wb.phys_rd]  <= wb.result;
                ready_q[wb.phys_rd] <= 1'b1;
            end
        end
    end

endmodule

//--- rtl/rename_dispatch.sv
`timescale 1ns/1ps

module rename_dispatch (
    input  logic              clk,
    input  logic              rst,
    input  logic              instr_valid_i,
    input  isa_pkg::instr_u   instr_i,
    output logic              stall_o,
    dispatch_if.rename        disp,
    output core_pkg::preg_t   rd_tag1_o,
    output core_pkg::preg_t   rd_tag2_o,
    input  core_pkg::xdata_t  rd_val1_i,
    input  core_pkg::xdata_t  rd_val2_i,
    input  logic              rd_rdy1_i,
    input  logic              rd_rdy2_i,
    input  logic              free_valid_i,
    input  core_pkg::preg_t   free_preg_i
);
    import isa_pkg::*;
    import core_pkg::*;

    preg_t              map_q [ARCH_REGS];    // Speculative rename table
    preg_t              fl_q [FREE_REGS];     // Circular free list
    logic [FREE_W-1:0]  fl_head_q;
    logic [FREE_W-1:0]  fl_tail_q;
    logic [FREE_W:0]    fl_count_q;

    logic  is_arith_r;
    logic  is_arith_i;
    areg_t arch_rd;
    areg_t arch_rs1;
    areg_t arch_rs2;
    logic  needs_reg;
    logic  accept;
    logic  alloc;
    preg_t new_preg;

    // Decode
    assign is_arith_r = instr_i.r.opcode == OPCODE_ARITH_R;
    assign is_arith_i = instr_i.i.opcode == OPCODE_ARITH_I;
    assign arch_rd    = instr_i.r.rd;         // Same field in both forms
    assign arch_rs1   = instr_i.r.rs1;
    assign arch_rs2   = instr_i.r.rs2;
    assign needs_reg  = arch_rd != '0;        // x0 results are thrown away

    assign stall_o  = disp.rob_full | disp.iq_full | (fl_count_q == '0);
    assign accept   = instr_valid_i & (is_arith_r | is_arith_i) & ~stall_o;
    assign alloc    = accept & needs_reg;
    assign new_preg = fl_q[fl_head_q];

    // Immediates read physical register 0 as rs2
    assign rd_tag1_o = map_q[arch_rs1];
    assign rd_tag2_o = is_arith_i ? '0 : map_q[arch_rs2];

    assign disp.valid       = accept;
    assign disp.arch_rd     = arch_rd;
    assign disp.phys_rd     = needs_reg ? new_preg : '0;
    assign disp.old_phys_rd = needs_reg ? map_q[arch_rd] : '0;
    assign disp.phys_rs1    = rd_tag1_o;
    assign disp.phys_rs2    = rd_tag2_o;
    assign disp.rs1_ready   = rd_rdy1_i;
    assign disp.rs2_ready   = rd_rdy2_i;
    assign disp.rs1_value   = rd_val1_i;
    assign disp.rs2_value   = rd_val2_i;
    assign disp.imm         = {{(XLEN-12){instr_i.i.imm[11]}}, instr_i.i.imm};
    assign disp.use_imm     = is_arith_i;
    assign disp.is_sub      = is_arith_r & instr_i.r.funct7[FUNCT7_SUB_BIT];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= PREG_W'(i);       // Identity mapping
            end
            for (int i = 0; i < FREE_REGS; i++) begin
                fl_q[i] <= PREG_W'(ARCH_REGS + i);
            end
            fl_head_q  <= '0;
            fl_tail_q  <= '0;                 // Equal pointers with a full count
            fl_count_q <= (FREE_W+1)'(FREE_REGS);
        end else begin
            if (alloc) begin
                map_q[arch_rd] <= new_preg;
                fl_head_q      <= fl_head_q + 1'b1;
            end
            // Registers released by commit go back at the tail
            if (free_valid_i) begin
                fl_q[fl_tail_q] <= free_preg_i;
                fl_tail_q       <= fl_tail_q + 1'b1;
            end
            fl_count_q <= fl_count_q + (FREE_W+1)'(free_valid_i) - (FREE_W+1)'(alloc);
        end
    end

endmodule

//--- rtl/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer (
    input  logic              clk,
    input  logic              rst,
    dispatch_if.rob           disp,
    result_if.dst             wb,
    output logic              free_valid_o,
    output core_pkg::preg_t   free_preg_o,
    output logic              commit_valid_o,
    output core_pkg::areg_t   commit_rd_o,
    output core_pkg::xdata_t  commit_data_o
);
    import core_pkg::*;

    rob_idx_t             head_q;
    rob_idx_t             tail_q;
    logic [ROB_W:0]       count_q;
    logic [ROB_DEPTH-1:0] done_q;
    areg_t                rd_q [ROB_DEPTH];
    preg_t                old_q [ROB_DEPTH];   // Previous mapping of rd
    xdata_t               data_q [ROB_DEPTH];
    logic                 commit_fire;

    assign commit_fire   = (count_q != '0) && done_q[head_q];
    assign disp.rob_idx  = tail_q;
    assign disp.rob_full = count_q == (ROB_W+1)'(ROB_DEPTH);

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q         <= '0;
            tail_q         <= '0;
            count_q        <= '0;
            done_q         <= '0;
            commit_valid_o <= 1'b0;
            free_valid_o   <= 1'b0;
        end else begin
            if (disp.valid) begin
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;  // Depth is a power of two
            end
            if (wb.valid) begin
                done_q[wb.rob_idx] <= 1'b1;
            end
            if (commit_fire) begin
                head_q <= head_q + 1'b1;
            end
            count_q <= count_q + (ROB_W+1)'(disp.valid) - (ROB_W+1)'(commit_fire);
            commit_valid_o <= commit_fire;
            // Physical register 0 is never handed out
            free_valid_o   <= commit_fire && old_q[head_q] != '0;
        end
    end

    always_ff @(posedge clk) begin
        if (disp.valid) begin
            rd_q[tail_q]  <= disp.arch_rd;
            old_q[tail_q] <= disp.old_phys_rd;
        end
        if (wb.valid) begin
            data_q[wb.rob_idx] <= wb.result;
        end
        if (commit_fire) begin
            commit_rd_o   <= rd_q[head_q];
            commit_data_o <= data_q[head_q];
            free_preg_o   <= old_q[head_q];
        end
    end

endmodule

//--- verif/core_trace.txt
# T <1 if stall_o must rise> <name>, I <instruction hex>, G <idle cycles>
# C <arch rd, decimal> <commit data hex>, listed in commit order
T 0 reset_addi
I 00500093
I FFD00113
C 1 00000005
C 2 FFFFFFFD
T 0 dep_chain
I 00A08193
I 00218233
I 401202B3
I 40510333
I 00630333
I 7FF30393
C 3 0000000F
C 4 0000000C
C 5 00000007
C 6 FFFFFFF6
C 6 FFFFFFEC
C 7 000007EB
T 0 ooo_independent
I 00738433
I 401404B3
I 06400513
I FFF50593
C 8 00000FD6
C 9 00000FD1
C 10 00000064
C 11 00000063
T 0 x0_write
I 02A08013
G 3
I 00100633
I 00000693
C 0 0000002F
C 12 00000005
C 13 00000000
T 1 burst
I 00770713
I 00E70733
I 00770713
I 00E70733
I 00770713
I 00E70733
I 00770713
I 00E70733
I 00770713
I 00E70733
I 00770713
I 00E70733
I 00770713
I 00E70733
I 00770713
I 00E70733
I 00770713
I 00E70733
I 00770713
I 00E70733
C 14 00000007
C 14 0000000E
C 14 00000015
C 14 0000002A
C 14 00000031
C 14 00000062
C 14 00000069
C 14 000000D2
C 14 000000D9
C 14 000001B2
C 14 000001B9
C 14 00000372
C 14 00000379
C 14 000006F2
C 14 000006F9
C 14 00000DF2
C 14 00000DF9
C 14 00001BF2
C 14 00001BF9
C 14 000037F2
T 0 unsupported_opcode
I 00900813
I 00002803
I 0000006F
I 010808B3
C 16 00000009
C 17 00000012

//--- verif/tb_ooo_core.sv
`timescale 1ns/1ps

module tb_ooo_core;

    localparam int TIMEOUT_CYCLES = 500;
    localparam int DRAIN_CYCLES   = 20;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic        stall;
    logic        commit_valid;
    logic [4:0]  commit_rd;
    logic [31:0] commit_data;

    // Parsed trace with one slice of ops and commits per test
    string       test_name [$];
    int          test_needs_stall [$];
    int          test_op_first [$];
    int          test_exp_first [$];
    bit          op_is_gap [$];
    logic [31:0] op_val [$];
    int          exp_rd [$];
    logic [31:0] exp_data [$];

    // Commits still owed by the running test
    int          pend_rd [$];
    logic [31:0] pend_data [$];

    int          errors;
    int          tests_passed;
    int          tests_failed;
    bit          aborted;
    bit          stall_seen;
    int          mon_rd;
    logic [31:0] mon_data;

    ooo_core dut0 (
        .clk            (clk),
        .rst            (rst),
        .instr_valid_i  (instr_valid),
        .instr_i        (instr),
        .stall_o        (stall),
        .commit_valid_o (commit_valid),
        .commit_rd_o    (commit_rd),
        .commit_data_o  (commit_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Commit monitor sampling registered outputs at the rising edge
    always @(posedge clk) begin
        if (!rst) begin
            if (stall) begin
                stall_seen = 1'b1;
            end
            if (commit_valid) begin
                assert (pend_rd.size() != 0) else begin
                    $display("Unexpected commit of x%0d with data %h",
                             commit_rd, commit_data);
                    errors++;
                end
                if (pend_rd.size() != 0) begin
                    mon_rd   = pend_rd.pop_front();
                    mon_data = pend_data.pop_front();
                    assert (int'(commit_rd) == mon_rd) else begin
                        $display("CHECK FAILED commit_rd_o: expected %h, got %h",
                                 mon_rd[4:0], commit_rd);
                        errors++;
                    end
                    assert (commit_data == mon_data) else begin
                        $display("CHECK FAILED commit_data_o: expected %h, got %h",
                                 mon_data, commit_data);
                        errors++;
                    end
                end
            end
        end
    end

    // Cuts trailing blanks and line ends off a trace line
    function automatic string strip_line_end(string s, int start);
        int stop;
        stop = s.len() - 1;
        while (stop >= start && (s.getc(stop) == 8'h0A || s.getc(stop) == 8'h0D
                                 || s.getc(stop) == 8'h20)) begin
            stop--;
        end
        return s.substr(start, stop);
    endfunction

    function automatic int op_last(int t);
        return (t + 1 < test_name.size()) ? test_op_first[t+1] : op_val.size();
    endfunction

    function automatic int exp_last(int t);
        return (t + 1 < test_name.size()) ? test_exp_first[t+1] : exp_rd.size();
    endfunction

    task automatic load_trace();
        int          fd;
        int          code;
        int          num;
        logic [31:0] word;
        string       line;
        fd = $fopen("verif/core_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file verif/core_trace.txt");
            errors++;
            aborted = 1'b1;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code > 0) begin
                case (line.getc(0))
                    "T": begin
                        code = $sscanf(line, "T %d", num);
                        test_name.push_back(strip_line_end(line, 4));
                        test_needs_stall.push_back(num);
                        test_op_first.push_back(op_val.size());
                        test_exp_first.push_back(exp_rd.size());
                    end
                    "I", "G": begin
                        if (line.getc(0) == "I") begin
                            code = $sscanf(line, "I %h", word);
                        end else begin
                            code = $sscanf(line, "G %d", word);
                        end
                        op_is_gap.push_back(line.getc(0) == "G");
                        op_val.push_back(word);
                    end
                    "C": begin
                        code = $sscanf(line, "C %d %h", num, word);
                        exp_rd.push_back(num);
                        exp_data.push_back(word);
                    end
                    default: code = 1;                // Comments and blank lines
                endcase
                if (code < 1) begin
                    $display("Malformed trace line: %s", strip_line_end(line, 0));
                    errors++;
                end
            end
        end
        $fclose(fd);
        if (test_name.size() == 0) begin
            $display("The trace file holds no test");
            errors++;
        end
    endtask

    // Holds the instruction until an edge with stall_o low takes it
    task automatic drive_instr(logic [31:0] word);
        int cycles;
        bit taken;
        cycles = 0;
        taken  = 1'b0;
        instr_valid <= 1'b1;
        instr       <= word;
        while (!taken && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
            taken = !stall;
        end
        if (!taken) begin
            $display("Instruction %h was never accepted, stall_o stayed high", word);
            errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic idle_cycles(int n);
        instr_valid <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic await_commits(int t);
        int cycles;
        int missing;
        cycles = 0;
        while (pend_rd.size() != 0 && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (pend_rd.size() != 0) begin
            missing = exp_last(t) - test_exp_first[t] - pend_rd.size() + 1;
            $display("Timeout in %s: commit %0d (x%0d) never came within %0d cycles",
                     test_name[t], missing, pend_rd[0], TIMEOUT_CYCLES);
            errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic run_test(int t);
        int errors_before;
        errors_before = errors;
        stall_seen    = 1'b0;
        for (int e = test_exp_first[t]; e < exp_last(t); e++) begin
            pend_rd.push_back(exp_rd[e]);
            pend_data.push_back(exp_data[e]);
        end
        for (int k = test_op_first[t]; k < op_last(t) && !aborted; k++) begin
            if (op_is_gap[k]) begin
                idle_cycles(int'(op_val[k]));
            end else begin
                drive_instr(op_val[k]);
            end
        end
        instr_valid <= 1'b0;
        if (!aborted) begin
            await_commits(t);
        end
        if (test_needs_stall[t] != 0) begin
            assert (stall_seen) else begin
                $display("CHECK FAILED stall_o: expected 1, got 0 through %s", test_name[t]);
                errors++;
            end
        end
        if (errors == errors_before) begin
            tests_passed++;
            $display("%-20s passed", test_name[t]);
        end else begin
            tests_failed++;
            $display("%-20s failed with %0d errors", test_name[t], errors - errors_before);
        end
    endtask

    initial begin
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        aborted      = 1'b0;
        stall_seen   = 1'b0;
        rst          = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        load_trace();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        assert (commit_valid == 1'b0) else begin
            $display("CHECK FAILED commit_valid_o: expected 0, got %h", commit_valid);
            errors++;
        end
        assert (stall == 1'b0) else begin
            $display("CHECK FAILED stall_o: expected 0, got %h", stall);
            errors++;
        end
        for (int t = 0; t < test_name.size() && !aborted; t++) begin
            run_test(t);
        end
        if (!aborted) begin
            idle_cycles(DRAIN_CYCLES);                // Catches stray late commits
        end
        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0 && !aborted) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
